// File: flist.f
source/bbcPkg.sv
source/sheilaDecode.sv
source/crtcTiming.sv
source/screenMemory.sv
source/videoUla.sv
source/bbcVideoTop.sv
sim/bbcVideoTb.sv

// File: run.sh
#!/bin/sh
# Build and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module bbcVideoTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1

// File: sim/bbcVideoTb.sv
`timescale 1ns/1ps

module bbcVideoTb;
	import bbcPkg::*;

	localparam int WaitLimit = 20000;
	localparam cpuAddress CrtcIndexAddr = 16'hFE00;
	localparam cpuAddress CrtcDataAddr = 16'hFE01;
	localparam cpuAddress UlaControlAddr = 16'hFE20;
	localparam cpuAddress UlaPaletteAddr = 16'hFE21;
	localparam cpuAddress LatchAddr = 16'hFE40;

	// Raster shared by the video tests
	localparam int HTotal = 15;
	localparam int HDisplayed = 10;
	localparam int HSyncPos = 12;
	localparam int SyncWidths = 8'h32;
	localparam int VTotal = 4;
	localparam int VDisplayed = 3;
	localparam int VSyncPos = 3;
	localparam int MaxScan = 1;
	localparam int LineStart = 16'h0100;

	logic       CLK100MHZ;
	logic       CPU_RESETN;
	cpuAddress  cpuAddr;
	busByte     cpuWriteData;
	logic       cpuWrite;
	logic       cpuRead;
	busByte     cpuReadData;
	logic [3:0] VGA_R;
	logic [3:0] VGA_G;
	logic [3:0] VGA_B;
	logic       VGA_HS;
	logic       VGA_VS;

	logic [31:0] lfsrState;
	int          errorCount;
	int          testStartErrors;
	int          testsRun;
	int          failedTests;
	logic        abortRun;
	busByte      lineBytes [16];
	rgbPixel     tbPalette [16];

	bbcVideoTop #(
		.RamAddressBits (15)
	) dut0 (
		.CLK100MHZ    (CLK100MHZ),
		.CPU_RESETN   (CPU_RESETN),
		.cpuAddr      (cpuAddr),
		.cpuWriteData (cpuWriteData),
		.cpuWrite     (cpuWrite),
		.cpuRead      (cpuRead),
		.cpuReadData  (cpuReadData),
		.VGA_R        (VGA_R),
		.VGA_G        (VGA_G),
		.VGA_B        (VGA_B),
		.VGA_HS       (VGA_HS),
		.VGA_VS       (VGA_VS)
	);

	initial begin
		CLK100MHZ = 1'b0;
		forever #5 CLK100MHZ = ~CLK100MHZ;
	end

	task automatic compareByte(input string name, input busByte got, input busByte expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic comparePixel(input string name, input rgbPixel got, input rgbPixel expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
			errorCount++;
		end
	endtask

	task automatic compareCount(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("FAILED %s: got %h expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timed out waiting for %s", what);
		errorCount++;
		abortRun = 1'b1;
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] result;
		logic        newBit;
		result = '0;
		for (int i = 0; i < count; i++) begin
			newBit = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], newBit};
			result = {result[30:0], newBit};
		end
		return result;
	endfunction

	// Every DAC bit of a gun carries the same colour bit
	task automatic checkPixelPins(input string name, input rgbPixel expected);
		for (int b = 0; b < 4; b++) begin
			comparePixel(name, {VGA_R[b], VGA_G[b], VGA_B[b]}, expected);
		end
	endtask

	function automatic logic sampleSync(input int which);
		return (which == 0) ? VGA_HS : VGA_VS;
	endfunction

	// Stay off the clock that belongs to the video fetch
	task automatic waitBusSlot();
		int n;
		n = 0;
		while (dut0.memory0.fetchSlot && n < WaitLimit) begin
			@(negedge CLK100MHZ);
			n++;
		end
		if (n >= WaitLimit) begin
			reportTimeout("a free bus slot");
		end
	endtask

	task automatic busWrite(input cpuAddress addr, input busByte data);
		@(negedge CLK100MHZ);
		waitBusSlot();
		cpuAddr = addr;
		cpuWriteData = data;
		cpuWrite = 1'b1;
		@(negedge CLK100MHZ);
		cpuWrite = 1'b0;
	endtask

	task automatic busRead(input cpuAddress addr, output busByte data);
		@(negedge CLK100MHZ);
		waitBusSlot();
		cpuAddr = addr;
		cpuRead = 1'b1;
		@(negedge CLK100MHZ);
		cpuRead = 1'b0;
		data = cpuReadData;
	endtask

	task automatic crtcWriteReg(input int index, input int value);
		busWrite(CrtcIndexAddr, busByte'(index));
		busWrite(CrtcDataAddr, busByte'(value));
	endtask

	task automatic setPalette(input int index, input rgbPixel colour);
		busWrite(UlaPaletteAddr, {4'(index), 1'b0, colour});
		tbPalette[index] = colour;
	endtask

	task automatic setLatchBit(input int bitIndex, input logic value);
		busWrite(LatchAddr, {4'd0, value, 3'(bitIndex)});
	endtask

	task automatic setStart(input int addr);
		crtcWriteReg(12, (addr >> 8) & 8'h3F);
		crtcWriteReg(13, addr & 8'hFF);
	endtask

	task automatic programRaster();
		crtcWriteReg(0, HTotal);
		crtcWriteReg(1, HDisplayed);
		crtcWriteReg(2, HSyncPos);
		crtcWriteReg(3, SyncWidths);
		crtcWriteReg(4, VTotal);
		crtcWriteReg(6, VDisplayed);
		crtcWriteReg(7, VSyncPos);
		crtcWriteReg(9, MaxScan);
	endtask

	// which is 0 for VGA_HS, 1 for VGA_VS
	task automatic waitSyncRise(input int which, input string name);
		logic prev;
		logic cur;
		logic done;
		int   n;
		@(negedge CLK100MHZ);
		prev = sampleSync(which);
		done = 1'b0;
		n = 0;
		while (!done && n < WaitLimit) begin
			@(negedge CLK100MHZ);
			n++;
			cur = sampleSync(which);
			if (!prev && cur) begin
				done = 1'b1;
			end
			prev = cur;
		end
		if (!done) begin
			reportTimeout(name);
		end
	endtask

	task automatic measureHs(output int period, output int width);
		int n;
		period = 0;
		width = 0;
		waitSyncRise(0, "VGA_HS rise");
		if (abortRun) return;
		width = 1;
		n = 0;
		@(negedge CLK100MHZ);
		while (VGA_HS && n < WaitLimit) begin
			width++;
			n++;
			@(negedge CLK100MHZ);
		end
		period = width;
		while (!VGA_HS && n < WaitLimit) begin
			period++;
			n++;
			@(negedge CLK100MHZ);
		end
		if (n >= WaitLimit) begin
			reportTimeout("the end of a VGA_HS period");
		end
	endtask

	// Lands on the clock of the first pixel of row 0, scanline 0
	task automatic findFirstLine(input int charClocks);
		waitSyncRise(1, "VGA_VS rise");
		if (abortRun) return;
		// Lines left from the vSync row to the end of the frame
		repeat ((VTotal + 1 - VSyncPos) * (MaxScan + 1)) begin
			waitSyncRise(0, "VGA_HS rise");
			if (abortRun) return;
		end
		for (int i = 0; i < (HTotal + 1 - HSyncPos) * charClocks; i++) begin
			checkPixelPins("border pixel", 3'b000);
			@(negedge CLK100MHZ);
		end
	endtask

	task automatic checkLine(input int charClocks, input int bpp, input int numChars,
		input logic checkBorder);
		int         k;
		int         t;
		int         p;
		int         clocksPerPixel;
		logic [7:0] logical;
		clocksPerPixel = charClocks * bpp / 8;
		for (int i = 0; i < numChars * charClocks; i++) begin
			k = i / charClocks;
			t = i % charClocks;
			p = t / clocksPerPixel;
			logical = 8'((lineBytes[k] >> (8 - bpp * (p + 1))) & ((1 << bpp) - 1));
			checkPixelPins("pixel", tbPalette[logical[3:0]]);
			@(negedge CLK100MHZ);
		end
		if (checkBorder) begin
			for (int i = 0; i < 2 * charClocks; i++) begin
				checkPixelPins("right border pixel", 3'b000);
				@(negedge CLK100MHZ);
			end
		end
	endtask

	task automatic fillLine(input int numChars);
		for (int c = 0; c < numChars; c++) begin
			lineBytes[c] = busByte'(takeBits(8));
			busWrite(cpuAddress'((LineStart + c) * 8), lineBytes[c]);
		end
	endtask

	task automatic startTest();
		testStartErrors = errorCount;
	endtask

	task automatic finishTest(input string name);
		int n;
		n = errorCount - testStartErrors;
		testsRun++;
		if (n != 0) begin
			failedTests++;
			$display("%s: failed with %0d errors", name, n);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic ramAccessTest();
		logic [31:0] r;
		cpuAddress   addr;
		busByte      data;
		busByte      got;
		startTest();
		repeat (16) begin
			r = takeBits(15);
			addr = {1'b0, r[14:0]};
			data = busByte'(takeBits(8));
			busWrite(addr, data);
			busRead(addr, got);
			compareByte("cpuReadData", got, data);
		end
		busRead(16'hFE00, got);
		compareByte("cpuReadData from SHEILA", got, 8'hFF);
		busRead(16'hFE4F, got);
		compareByte("cpuReadData from SHEILA", got, 8'hFF);
		finishTest("RAM access");
	endtask

	task automatic horizontalTest();
		int period;
		int width;
		startTest();
		programRaster();
		busWrite(UlaControlAddr, 8'h10);
		// First measurement may straddle the register change
		measureHs(period, width);
		measureHs(period, width);
		compareCount("VGA_HS period fast", period, (HTotal + 1) * 8);
		compareCount("VGA_HS width fast", width, (SyncWidths & 4'hF) * 8);
		if (!abortRun) begin
			busWrite(UlaControlAddr, 8'h00);
			measureHs(period, width);
			measureHs(period, width);
			compareCount("VGA_HS period slow", period, (HTotal + 1) * 16);
			compareCount("VGA_HS width slow", width, (SyncWidths & 4'hF) * 16);
		end
		finishTest("horizontal timing");
	endtask

	task automatic verticalTest();
		logic prevHs;
		logic prevVs;
		logic done;
		int   total;
		int   inWidth;
		int   n;
		startTest();
		busWrite(UlaControlAddr, 8'h10);
		waitSyncRise(1, "VGA_VS rise");
		waitSyncRise(1, "VGA_VS rise");
		prevHs = VGA_HS;
		prevVs = VGA_VS;
		done = abortRun;
		total = 0;
		inWidth = 0;
		n = 0;
		while (!done && n < WaitLimit) begin
			@(negedge CLK100MHZ);
			n++;
			if (!prevHs && VGA_HS) begin
				total++;
				if (VGA_VS) begin
					inWidth++;
				end
			end
			if (!prevVs && VGA_VS) begin
				done = 1'b1;
			end
			prevHs = VGA_HS;
			prevVs = VGA_VS;
		end
		if (!done) begin
			reportTimeout("the next VGA_VS rise");
		end else begin
			compareCount("VGA_HS rises per frame", total, (VTotal + 1) * (MaxScan + 1));
			compareCount("VGA_HS rises during VGA_VS", inWidth, SyncWidths >> 4);
		end
		finishTest("vertical timing");
	endtask

	task automatic pixelFastTest();
		rgbPixel background;
		startTest();
		busWrite(UlaControlAddr, 8'h10);
		setStart(LineStart);
		fillLine(HDisplayed);
		// Complementary colours so every bit of a byte shows
		background = rgbPixel'(takeBits(3));
		setPalette(0, background);
		setPalette(1, ~background);
		findFirstLine(8);
		if (!abortRun) begin
			checkLine(8, 1, HDisplayed, 1'b1);
		end
		finishTest("pixels at 1 bpp");
	endtask

	task automatic pixelSlowTest();
		int bpp;
		startTest();
		for (int pass = 0; pass < 2 && !abortRun; pass++) begin
			bpp = (pass == 0) ? 2 : 4;
			// Slow mode, bits 3:2 hold the depth code
			busWrite(UlaControlAddr, (pass == 0) ? 8'h04 : 8'h08);
			for (int i = 0; i < 16; i++) begin
				setPalette(i, rgbPixel'(takeBits(3)));
			end
			fillLine(HDisplayed);
			waitSyncRise(1, "VGA_VS rise");
			findFirstLine(16);
			if (!abortRun) begin
				checkLine(16, bpp, HDisplayed, 1'b1);
			end
		end
		finishTest("pixels at 2 and 4 bpp");
	endtask

	task automatic wrapTest();
		int          wrapTable [4];
		busByte      wrapBytes [4];
		logic [31:0] r;
		int          high;
		wrapTable = '{8, 12, 6, 11};
		startTest();
		busWrite(UlaControlAddr, 8'h10);
		setPalette(0, 3'b000);
		setPalette(1, 3'b111);
		// Bit 12 set, bits 11:8 = 2
		setStart(16'h1200);
		for (int s = 0; s < 4; s++) begin
			high = (2 + wrapTable[s]) % 16;
			r = takeBits(6);
			wrapBytes[s] = {r[5:0], 2'(s)};
			busWrite(cpuAddress'(high << 11), wrapBytes[s]);
		end
		for (int s = 0; s < 4 && !abortRun; s++) begin
			setLatchBit(4, s[0]);
			setLatchBit(5, s[1]);
			lineBytes[0] = wrapBytes[s];
			findFirstLine(8);
			if (!abortRun) begin
				checkLine(8, 1, 1, 1'b0);
			end
		end
		finishTest("wraparound");
	endtask

	initial begin
		CPU_RESETN = 1'b0;
		cpuAddr = '0;
		cpuWriteData = '0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		lfsrState = 32'hb4dd_9b66;
		errorCount = 0;
		testStartErrors = 0;
		testsRun = 0;
		failedTests = 0;
		abortRun = 1'b0;
		for (int i = 0; i < 16; i++) begin
			tbPalette[i] = rgbPixel'(i);
			lineBytes[i] = '0;
		end
		repeat (2) @(posedge CLK100MHZ);
		@(negedge CLK100MHZ);
		CPU_RESETN = 1'b1;

		ramAccessTest();
		if (!abortRun) horizontalTest();
		if (!abortRun) verticalTest();
		if (!abortRun) pixelFastTest();
		if (!abortRun) pixelSlowTest();
		if (!abortRun) wrapTest();

		$display("%0d tests run, %0d failed, %0d errors", testsRun, failedTests, errorCount);
		if (errorCount == 0 && !abortRun) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: source/bbcPkg.sv
package bbcPkg;

	// Bus and memory data
	typedef logic [7:0] busByte;

	// Processor side address
	typedef logic [15:0] cpuAddress;

	// Timing generator memory address and scanline
	typedef logic [13:0] framestoreAddress;
	typedef logic [4:0] rowAddress;

	// Latch bits 5:4, picks the wraparound offset
	typedef logic [1:0] screenSize;

	// Red, green, blue in bits 2, 1, 0
	typedef logic [2:0] rgbPixel;

	// SHEILA page and device windows inside it
	localparam cpuAddress SheilaBase = 16'hFE00;
	localparam cpuAddress CrtcOffset = 16'h0000;
	localparam cpuAddress UlaOffset = 16'h0020;
	localparam cpuAddress LatchOffset = 16'h0040;

	// Hardware scroll wraparound, element n is the offset for screen size n
	localparam logic [3:0][3:0] WrapOffset = {
		4'd11,
		4'd6,
		4'd12,
		4'd8
	};

endpackage

// File: source/bbcVideoTop.sv
`timescale 1ns/1ps

module bbcVideoTop #(
	parameter int RamAddressBits = 15
) (
	input  logic              CLK100MHZ,
	input  logic              CPU_RESETN,
	input  bbcPkg::cpuAddress cpuAddr,
	input  bbcPkg::busByte    cpuWriteData,
	input  logic              cpuWrite,
	input  logic              cpuRead,
	output bbcPkg::busByte    cpuReadData,
	output logic [3:0]        VGA_R,
	output logic [3:0]        VGA_G,
	output logic [3:0]        VGA_B,
	output logic              VGA_HS,
	output logic              VGA_VS
);
	import bbcPkg::*;

	logic             crtcWrite;
	logic             ulaWrite;
	logic             ramWrite;
	logic             ramRead;
	logic             charTick;
	screenSize        latchScreenSize;
	framestoreAddress framestoreAddr;
	rowAddress        rowAddr;
	logic             displayEnable;
	logic             hSync;
	logic             vSync;
	busByte           videoByte;
	rgbPixel          pixel;

	sheilaDecode decode0 (
		.CLK100MHZ    (CLK100MHZ),
		.CPU_RESETN   (CPU_RESETN),
		.cpuAddr      (cpuAddr),
		.cpuWriteData (cpuWriteData),
		.cpuWrite     (cpuWrite),
		.cpuRead      (cpuRead),
		.crtcWrite    (crtcWrite),
		.ulaWrite     (ulaWrite),
		.ramWrite     (ramWrite),
		.ramRead      (ramRead),
		.screenSize   (latchScreenSize)
	);

	crtcTiming crtc0 (
		.CLK100MHZ      (CLK100MHZ),
		.CPU_RESETN     (CPU_RESETN),
		.charTick       (charTick),
		.crtcWrite      (crtcWrite),
		.registerSelect (cpuAddr[0]),
		.cpuWriteData   (cpuWriteData),
		.framestoreAddr (framestoreAddr),
		.rowAddr        (rowAddr),
		.displayEnable  (displayEnable),
		.hSync          (hSync),
		.vSync          (vSync)
	);

	screenMemory #(
		.RamAddressBits (RamAddressBits)
	) memory0 (
		.CLK100MHZ      (CLK100MHZ),
		.CPU_RESETN     (CPU_RESETN),
		.ramWrite       (ramWrite),
		.ramRead        (ramRead),
		.cpuAddr        (cpuAddr),
		.cpuWriteData   (cpuWriteData),
		.charTick       (charTick),
		.framestoreAddr (framestoreAddr),
		.rowAddr        (rowAddr),
		.screenSize     (latchScreenSize),
		.cpuReadData    (cpuReadData),
		.videoByte      (videoByte)
	);

	videoUla ula0 (
		.CLK100MHZ      (CLK100MHZ),
		.CPU_RESETN     (CPU_RESETN),
		.ulaWrite       (ulaWrite),
		.registerSelect (cpuAddr[0]),
		.cpuWriteData   (cpuWriteData),
		.videoByte      (videoByte),
		.displayEnable  (displayEnable),
		.hSync          (hSync),
		.vSync          (vSync),
		.charTick       (charTick),
		.pixel          (pixel),
		.syncH          (VGA_HS),
		.syncV          (VGA_VS)
	);

	// One bit per gun, spread over the 4 bit DAC
	assign VGA_R = {4{pixel[2]}};
	assign VGA_G = {4{pixel[1]}};
	assign VGA_B = {4{pixel[0]}};

endmodule

// File: source/crtcTiming.sv
`timescale 1ns/1ps

module crtcTiming (
	input  logic                      CLK100MHZ,
	input  logic                      CPU_RESETN,
	input  logic                      charTick,
	input  logic                      crtcWrite,
	input  logic                      registerSelect,
	input  bbcPkg::busByte            cpuWriteData,
	output bbcPkg::framestoreAddress  framestoreAddr,
	output bbcPkg::rowAddress         rowAddr,
	output logic                      displayEnable,
	output logic                      hSync,
	output logic                      vSync
);
	import bbcPkg::*;

	// Register file
	logic [4:0] regIndex;
	busByte     hTotal;
	busByte     hDisplayed;
	busByte     hSyncPos;
	busByte     syncWidths;
	logic [6:0] vTotal;
	logic [6:0] vDisplayed;
	logic [6:0] vSyncPos;
	logic [4:0] maxScanLine;
	logic [5:0] startHigh;
	busByte     startLow;

	// Raster position
	logic [7:0]       hCount;
	logic [4:0]       scanCount;
	logic [6:0]       rowCount;
	logic [3:0]       vSyncLeft;
	framestoreAddress rowStart;

	logic             lineEnd;
	logic             rowEnd;
	logic             frameEnd;
	logic [4:0]       nextScan;
	logic [6:0]       nextRow;
	logic [8:0]       hSyncEnd;
	framestoreAddress startAddr;

	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			regIndex <= '0;
			hTotal <= '0;
			hDisplayed <= '0;
			hSyncPos <= '0;
			syncWidths <= '0;
			vTotal <= '0;
			vDisplayed <= '0;
			vSyncPos <= '0;
			maxScanLine <= '0;
			startHigh <= '0;
			startLow <= '0;
		end else if (crtcWrite) begin
			if (!registerSelect) begin
				regIndex <= cpuWriteData[4:0];
			end else begin
				// Unsupported indices are dropped
				case (regIndex)
					5'd0: hTotal <= cpuWriteData;
					5'd1: hDisplayed <= cpuWriteData;
					5'd2: hSyncPos <= cpuWriteData;
					5'd3: syncWidths <= cpuWriteData;
					5'd4: vTotal <= cpuWriteData[6:0];
					5'd6: vDisplayed <= cpuWriteData[6:0];
					5'd7: vSyncPos <= cpuWriteData[6:0];
					5'd9: maxScanLine <= cpuWriteData[4:0];
					5'd12: startHigh <= cpuWriteData[5:0];
					5'd13: startLow <= cpuWriteData;
					default: ;
				endcase
			end
		end
	end

	// Compare with >= so a shortened total cannot run the counter away
	assign lineEnd = (hCount >= hTotal);
	assign rowEnd = (scanCount >= maxScanLine);
	assign frameEnd = rowEnd && (rowCount >= vTotal);

	assign nextScan = rowEnd ? 5'd0 : scanCount + 5'd1;
	assign nextRow = frameEnd ? 7'd0 : (rowEnd ? rowCount + 7'd1 : rowCount);

	assign hSyncEnd = {1'b0, hSyncPos} + {5'd0, syncWidths[3:0]};
	assign startAddr = {startHigh, startLow};

	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			hCount <= '0;
			scanCount <= '0;
			rowCount <= '0;
			vSyncLeft <= '0;
			rowStart <= '0;
		end else if (charTick) begin
			if (!lineEnd) begin
				hCount <= hCount + 8'd1;
			end else begin
				hCount <= '0;
				scanCount <= nextScan;
				rowCount <= nextRow;

				// Every scanline of a row reuses the same row start
				if (frameEnd) begin
					rowStart <= startAddr;
				end else if (rowEnd) begin
					rowStart <= rowStart + {6'd0, hDisplayed};
				end

				// Vertical sync counted in scanlines from the top of row R7
				if ((nextRow == vSyncPos) && (nextScan == 5'd0)) begin
					vSyncLeft <= syncWidths[7:4];
				end else if (vSyncLeft != 4'd0) begin
					vSyncLeft <= vSyncLeft - 4'd1;
				end
			end
		end
	end

	// Outputs describe the character the counters point at on this tick
	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			framestoreAddr <= '0;
			rowAddr <= '0;
			displayEnable <= 1'b0;
			hSync <= 1'b0;
			vSync <= 1'b0;
		end else if (charTick) begin
			framestoreAddr <= rowStart + {6'd0, hCount};
			rowAddr <= scanCount;
			displayEnable <= (hCount < hDisplayed) && (rowCount < vDisplayed);
			hSync <= ({1'b0, hCount} >= {1'b0, hSyncPos}) && ({1'b0, hCount} < hSyncEnd);
			vSync <= (vSyncLeft != 4'd0);
		end
	end

endmodule

// File: source/screenMemory.sv
`timescale 1ns/1ps

module screenMemory #(
	parameter int RamAddressBits = 15
) (
	input  logic                      CLK100MHZ,
	input  logic                      CPU_RESETN,
	input  logic                      ramWrite,
	input  logic                      ramRead,
	input  bbcPkg::cpuAddress         cpuAddr,
	input  bbcPkg::busByte            cpuWriteData,
	input  logic                      charTick,
	input  bbcPkg::framestoreAddress  framestoreAddr,
	input  bbcPkg::rowAddress         rowAddr,
	input  bbcPkg::screenSize         screenSize,
	output bbcPkg::busByte            cpuReadData,
	output bbcPkg::busByte            videoByte
);
	import bbcPkg::*;

	busByte                    ram [2**RamAddressBits];
	busByte                    cpuByte;
	logic                      fetchSlot;
	logic                      ramReadDone;
	logic                      offRam;
	logic [3:0]                wrapAdd;
	logic [3:0]                adjustedHigh;
	logic [14:0]               fetchFull;
	logic [RamAddressBits-1:0] fetchIndex;
	logic [RamAddressBits-1:0] cpuIndex;

	// Only addresses past the top of RAM get the wraparound offset
	assign wrapAdd = framestoreAddr[12] ? WrapOffset[screenSize] : 4'd0;
	assign adjustedHigh = framestoreAddr[11:8] + wrapAdd;
	assign fetchFull = {adjustedHigh, framestoreAddr[7:0], rowAddr[2:0]};
	assign fetchIndex = fetchFull[RamAddressBits-1:0];
	assign cpuIndex = cpuAddr[RamAddressBits-1:0];

	// One port, the clock after charTick belongs to video
	always_ff @(posedge CLK100MHZ) begin
		if (fetchSlot) begin
			videoByte <= ram[fetchIndex];
		end else if (ramWrite) begin
			ram[cpuIndex] <= cpuWriteData;
		end else if (ramRead) begin
			cpuByte <= ram[cpuIndex];
		end
	end

	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			fetchSlot <= 1'b0;
			ramReadDone <= 1'b0;
			offRam <= 1'b0;
		end else begin
			fetchSlot <= charTick;
			ramReadDone <= ramRead;
			offRam <= cpuAddr[15];
		end
	end

	// Nothing drives the data bus above RAM, so it floats high
	assign cpuReadData = ramReadDone ? cpuByte : {8{offRam}};

endmodule

// File: source/sheilaDecode.sv
`timescale 1ns/1ps

module sheilaDecode (
	input  logic               CLK100MHZ,
	input  logic               CPU_RESETN,
	input  bbcPkg::cpuAddress  cpuAddr,
	input  bbcPkg::busByte     cpuWriteData,
	input  logic               cpuWrite,
	input  logic               cpuRead,
	output logic               crtcWrite,
	output logic               ulaWrite,
	output logic               ramWrite,
	output logic               ramRead,
	output bbcPkg::screenSize  screenSize
);
	import bbcPkg::*;

	busByte systemLatch;
	busByte sheilaOffset;
	logic   inRam;
	logic   inSheila;
	logic   crtcSelect;
	logic   ulaSelect;
	logic   latchSelect;
	logic   latchWrite;

	// Lower 32 KiB is screen RAM
	assign inRam = ~cpuAddr[15];

	// FE00-FEFF
	assign inSheila = (cpuAddr[15:8] == SheilaBase[15:8]);
	assign sheilaOffset = cpuAddr[7:0];

	// CRTC is 8 bytes wide, ULA and latch are 16
	assign crtcSelect = inSheila && (sheilaOffset[7:3] == CrtcOffset[7:3]);
	assign ulaSelect = inSheila && (sheilaOffset[7:4] == UlaOffset[7:4]);
	assign latchSelect = inSheila && (sheilaOffset[7:4] == LatchOffset[7:4]);

	assign crtcWrite = cpuWrite && crtcSelect;
	assign ulaWrite = cpuWrite && ulaSelect;
	assign latchWrite = cpuWrite && latchSelect;
	assign ramWrite = cpuWrite && inRam;
	assign ramRead = cpuRead && inRam;

	// Addressable latch, D3 is the value and D2:0 the bit it goes to
	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			systemLatch <= '0;
		end else if (latchWrite) begin
			systemLatch[cpuWriteData[2:0]] <= cpuWriteData[3];
		end
	end

	assign screenSize = systemLatch[5:4];

endmodule

// File: source/videoUla.sv
`timescale 1ns/1ps

module videoUla (
	input  logic            CLK100MHZ,
	input  logic            CPU_RESETN,
	input  logic            ulaWrite,
	input  logic            registerSelect,
	input  bbcPkg::busByte  cpuWriteData,
	input  bbcPkg::busByte  videoByte,
	input  logic            displayEnable,
	input  logic            hSync,
	input  logic            vSync,
	output logic            charTick,
	output bbcPkg::rgbPixel pixel,
	output logic            syncH,
	output logic            syncV
);
	import bbcPkg::*;

	busByte     controlReg;
	rgbPixel    palette [16];
	logic [3:0] phase;
	logic       fastMode;
	logic [1:0] bppCode;
	logic [3:0] bitsPerPixel;
	logic [2:0] pixelShift;
	logic [3:0] pixelMask;
	logic       pixelLast;
	busByte     shiftReg;
	logic       displayActive;
	logic [3:0] logicalColour;

	// Bit 4 set means 8 clock characters
	assign fastMode = controlReg[4];

	// Code 3 behaves like 4 bpp
	assign bppCode = (controlReg[3:2] == 2'd3) ? 2'd2 : controlReg[3:2];
	assign bitsPerPixel = 4'd1 << bppCode;

	// log2 of clocks per pixel
	assign pixelShift = {1'b0, bppCode} + {2'b00, ~fastMode};
	assign pixelMask = (4'd1 << pixelShift) - 4'd1;

	assign pixelLast = ((phase & pixelMask) == pixelMask);
	assign charTick = fastMode ? (phase[2:0] == 3'd7) : (phase == 4'd15);

	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			controlReg <= 8'h10;
			for (int i = 0; i < 16; i++) begin
				palette[i] <= rgbPixel'(i);
			end
		end else if (ulaWrite) begin
			if (!registerSelect) begin
				controlReg <= cpuWriteData;
			end else begin
				// Logical colour in the high nibble
				palette[cpuWriteData[7:4]] <= cpuWriteData[2:0];
			end
		end
	end

	// Free running character clock
	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			phase <= '0;
		end else begin
			phase <= phase + 4'd1;
		end
	end

	// Syncs take the same one character delay as the pixel data
	always_ff @(posedge CLK100MHZ) begin
		if (!CPU_RESETN) begin
			displayActive <= 1'b0;
			syncH <= 1'b0;
			syncV <= 1'b0;
		end else if (charTick) begin
			displayActive <= displayEnable;
			syncH <= hSync;
			syncV <= vSync;
		end
	end

	// MSB first, one pixel width per shift
	always_ff @(posedge CLK100MHZ) begin
		if (charTick) begin
			shiftReg <= videoByte;
		end else if (pixelLast) begin
			shiftReg <= shiftReg << bitsPerPixel;
		end
	end

	always_comb begin
		case (bppCode)
			2'd0: logicalColour = {3'b000, shiftReg[7]};
			2'd1: logicalColour = {2'b00, shiftReg[7:6]};
			default: logicalColour = shiftReg[7:4];
		endcase
	end

	// Black border outside the displayed area
	assign pixel = displayActive ? palette[logicalColour] : 3'b000;

endmodule
